// File: build.f
rtl/pd_pkg.sv
rtl/edge_capture.sv
rtl/lead_lag_arbiter.sv
rtl/interval_counter.sv
rtl/phase_error_combiner.sv
rtl/phase_detector_top.sv
verification/phase_detector_tb.sv

// File: rtl/edge_capture.sv
module edge_capture (
    input  logic               done_c,
    input  logic               reset_i,
    input  logic               reference_i,
    input  logic               generated_i,
    output pd_pkg::edge_pair_t edges_o
);

    logic ref_cur_r;
    logic ref_prev_r;
    logic gen_cur_r;
    logic gen_prev_r;

    // The current sample is the first flop that sees the input, the
    // previous one holds it for one more cycle
    always_ff @(posedge done_c or posedge reset_i)
    begin
        if (reset_i)
        begin
            ref_cur_r  <= 1'b0;
            ref_prev_r <= 1'b0;
            gen_cur_r  <= 1'b0;
            gen_prev_r <= 1'b0;
        end
        else
        begin
            ref_cur_r  <= reference_i;
            ref_prev_r <= ref_cur_r;
            gen_cur_r  <= generated_i;
            gen_prev_r <= gen_cur_r;
        end
    end

    assign edges_o.ref_rise = ref_cur_r & ~ref_prev_r;  // High for the cycle after the first high sample
    assign edges_o.gen_rise = gen_cur_r & ~gen_prev_r;

endmodule

// File: rtl/interval_counter.sv
module interval_counter (
    input  logic               done_c,
    input  logic               reset_i,
    input  pd_pkg::edge_pair_t edges_i,
    input  pd_pkg::lead_t      lead_i,
    output pd_pkg::span_t      span_o
);

    logic                         running_r;
    logic [pd_pkg::MAG_WIDTH-1:0] count_r;
    logic                         any_rise_c;

    assign any_rise_c = edges_i.ref_rise | edges_i.gen_rise;

    // The count advances on every edge from the first pulse on, so in the
    // cycle of the second pulse it equals the edge distance between inputs
    always_ff @(posedge done_c or posedge reset_i)
    begin
        if (reset_i)
        begin
            running_r <= 1'b0;
            count_r   <= '0;
        end
        else if (lead_i.done)
        begin
            running_r <= 1'b0;
            count_r   <= '0;
        end
        else if (running_r)
        begin
            if (count_r != pd_pkg::MAG_MAX)
            begin
                count_r <= count_r + 1'b1;
            end
        end
        else if (any_rise_c)
        begin
            running_r <= 1'b1;
            count_r   <= {{(pd_pkg::MAG_WIDTH-1){1'b0}}, 1'b1};  // First edge already counts
        end
    end

    assign span_o.magnitude = count_r;  // Zero when both inputs rise together

    // Held at the limit rather than wrapping past it
    magnitude_limit_a : assert property (
        @(posedge done_c) disable iff (reset_i)
        (running_r && !lead_i.done) |=> (span_o.magnitude >= $past(span_o.magnitude))
    );

endmodule

// File: rtl/lead_lag_arbiter.sv
module lead_lag_arbiter (
    input  logic               done_c,
    input  logic               reset_i,
    input  pd_pkg::edge_pair_t edges_i,
    output pd_pkg::lead_t      lead_o
);

    logic seen_ref_r;
    logic seen_gen_r;
    logic gen_first_r;
    logic open_c;
    logic ref_hit_c;
    logic gen_hit_c;
    logic both_seen_c;

    assign open_c      = seen_ref_r | seen_gen_r;
    assign ref_hit_c   = seen_ref_r | edges_i.ref_rise;  // Repeat rises of a seen input change nothing
    assign gen_hit_c   = seen_gen_r | edges_i.gen_rise;
    assign both_seen_c = ref_hit_c & gen_hit_c;

    always_ff @(posedge done_c or posedge reset_i)
    begin
        if (reset_i)
        begin
            seen_ref_r  <= 1'b0;
            seen_gen_r  <= 1'b0;
            gen_first_r <= 1'b0;
        end
        else if (both_seen_c)
        begin
            // Measurement closes, back to idle
            seen_ref_r <= 1'b0;
            seen_gen_r <= 1'b0;
        end
        else
        begin
            seen_ref_r <= ref_hit_c;
            seen_gen_r <= gen_hit_c;
            // Only one input can rise here, a joint rise closes at once
            if (!open_c && (edges_i.ref_rise || edges_i.gen_rise))
            begin
                gen_first_r <= edges_i.gen_rise;
            end
        end
    end

    // Closing straight from idle means both rose together
    assign lead_o.done      = both_seen_c;
    assign lead_o.gen_first = open_c ? gen_first_r : 1'b0;

    // The sign reported at done is the one taken at the opening edge
    gen_first_held_a : assert property (
        @(posedge done_c) disable iff (reset_i)
        (open_c && !both_seen_c) |=> (lead_o.gen_first == $past(lead_o.gen_first))
    );

endmodule

// File: rtl/pd_pkg.sv
package pd_pkg;

    // Signed phase error, the sign bit plus the magnitude
    localparam int PD_WIDTH  = 5;
    localparam int MAG_WIDTH = PD_WIDTH - 1;

    // Largest distance in cycles that a measurement can report
    localparam logic [MAG_WIDTH-1:0] MAG_MAX = '1;

    // One-cycle pulses that mark the first high sample of each input
    typedef struct packed {
        logic ref_rise;
        logic gen_rise;
    } edge_pair_t;

    typedef struct packed {
        logic done;       // Both edges of the measurement are in
        logic gen_first;  // Generated edge came strictly earlier
    } lead_t;

    typedef struct packed {
        logic [MAG_WIDTH-1:0] magnitude;
    } span_t;

endpackage

// File: rtl/phase_detector_top.sv
module phase_detector_top (
    input  logic                               done_c,
    input  logic                               reset_i,
    input  logic                               reference_i,
    input  logic                               generated_i,
    output logic signed [pd_pkg::PD_WIDTH-1:0] pd_error_o,
    output logic                               gen_leads_o,
    output logic                               pd_valid_o
);

    pd_pkg::edge_pair_t edges_c;
    pd_pkg::lead_t      lead_c;
    pd_pkg::span_t      span_c;

    edge_capture u_edge_capture (
        .done_c      (done_c),
        .reset_i     (reset_i),
        .reference_i (reference_i),
        .generated_i (generated_i),
        .edges_o     (edges_c)
    );

    // Sign and magnitude are found side by side from the same pulses
    lead_lag_arbiter u_lead_lag_arbiter (
        .done_c  (done_c),
        .reset_i (reset_i),
        .edges_i (edges_c),
        .lead_o  (lead_c)
    );

    interval_counter u_interval_counter (
        .done_c  (done_c),
        .reset_i (reset_i),
        .edges_i (edges_c),
        .lead_i  (lead_c),    // Done clears the count
        .span_o  (span_c)
    );

    phase_error_combiner u_phase_error_combiner (
        .done_c      (done_c),
        .reset_i     (reset_i),
        .lead_i      (lead_c),
        .span_i      (span_c),
        .pd_error_o  (pd_error_o),
        .gen_leads_o (gen_leads_o),
        .pd_valid_o  (pd_valid_o)
    );

endmodule

// File: rtl/phase_error_combiner.sv
module phase_error_combiner (
    input  logic                               done_c,
    input  logic                               reset_i,
    input  pd_pkg::lead_t                      lead_i,
    input  pd_pkg::span_t                      span_i,
    output logic signed [pd_pkg::PD_WIDTH-1:0] pd_error_o,
    output logic                               gen_leads_o,
    output logic                               pd_valid_o
);

    logic [pd_pkg::PD_WIDTH-1:0]        mag_ext_c;
    logic [pd_pkg::PD_WIDTH-1:0]        error_next_c;
    logic signed [pd_pkg::PD_WIDTH-1:0] error_r;
    logic                               gen_leads_r;
    logic                               valid_r;

    assign mag_ext_c = {1'b0, span_i.magnitude};

    // Two's complement when the generated signal leads
    assign error_next_c = lead_i.gen_first ? (~mag_ext_c + 1'b1) : mag_ext_c;

    always_ff @(posedge done_c or posedge reset_i)
    begin
        if (reset_i)
        begin
            error_r     <= '0;
            gen_leads_r <= 1'b0;
            valid_r     <= 1'b0;
        end
        else
        begin
            valid_r <= lead_i.done;
            if (lead_i.done)
            begin
                error_r     <= $signed(error_next_c);
                gen_leads_r <= lead_i.gen_first;
            end
        end
    end

    assign pd_error_o  = error_r;  // Holds until the next result
    assign gen_leads_o = gen_leads_r;
    assign pd_valid_o  = valid_r;

    // A result needs a full new measurement, so valid can never repeat at once
    valid_single_pulse_a : assert property (
        @(posedge done_c) disable iff (reset_i)
        pd_valid_o |=> !pd_valid_o
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the phase detector testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
    --top-module phase_detector_tb -o sim_phase_detector
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_phase_detector)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -F -q '*** PASSED ***'; then
    echo "Simulation reported success"
    exit 0
else
    echo "Simulation did not report success"
    exit 1
fi

// File: verification/phase_detector_tb.sv
module phase_detector_tb;

    localparam int ROWS          = 16;
    localparam int FIXED_ROWS    = 10;
    localparam int VALID_LATENCY = 2;   // Edges from the later input's drive edge to valid
    localparam int VALID_WAIT    = 12;
    localparam int HOLD_CYCLES   = 6;
    localparam int IDLE_CYCLES   = 4;

    logic                               done_c = 1'b0;
    logic                               reset_i;
    logic                               reference_i;
    logic                               generated_i;
    logic signed [pd_pkg::PD_WIDTH-1:0] pd_error_o;
    logic                               gen_leads_o;
    logic                               pd_valid_o;

    int     ref_off [ROWS];
    int     gen_off [ROWS];
    int     exp_err [ROWS];
    logic   exp_sign [ROWS];
    integer seed;
    int     max_off;
    int     cycle_count = 0;
    int     cycle_limit = 0;
    int     pass_count;
    int     fail_count;
    int     row_errors;

    phase_detector_top dut (
        .done_c      (done_c),
        .reset_i     (reset_i),
        .reference_i (reference_i),
        .generated_i (generated_i),
        .pd_error_o  (pd_error_o),
        .gen_leads_o (gen_leads_o),
        .pd_valid_o  (pd_valid_o)
    );

    always #10 done_c = ~done_c;

    always @(posedge done_c)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Signed error from the measurement rule, saturated at the largest magnitude
    function int rule_error(input int r, input int g);
        int mag;
        if (g >= r)
            mag = g - r;
        else
            mag = r - g;
        if (mag > int'(pd_pkg::MAG_MAX))
            mag = int'(pd_pkg::MAG_MAX);
        return (g < r) ? -mag : mag;
    endfunction

    task set_row(input int idx, input int r, input int g, input int e, input logic s);
        ref_off[idx]  = r;
        gen_off[idx]  = g;
        exp_err[idx]  = e;
        exp_sign[idx] = s;
    endtask

    task report_value(input string name, input int got, input int expected);
        $display("ERR %0t %s got %0d expected %0d", $time, name, got, expected);
        row_errors++;
    endtask

    task report_failure(input string what);
        $display("%0t %s", $time, what);
        row_errors++;
    endtask

    task close_test(input string label);
        if (row_errors == 0)
        begin
            pass_count++;
            $display("test %s ok", label);
        end
        else
        begin
            fail_count++;
            $display("test %s failed with %0d errors", label, row_errors);
        end
    endtask

    task check_outputs(input int row);
        if ($isunknown(pd_error_o) || int'(pd_error_o) != exp_err[row])
            report_value("pd_error_o", int'(pd_error_o), exp_err[row]);
        if (gen_leads_o !== exp_sign[row])
            report_value("gen_leads_o", int'(gen_leads_o), int'(exp_sign[row]));
    endtask

    task run_row(input int row);
        int   later;
        int   k;
        int   edges;
        logic got;
        later = (ref_off[row] > gen_off[row]) ? ref_off[row] : gen_off[row];
        row_errors = 0;
        @(posedge done_c);
        reference_i <= 1'b0;
        generated_i <= 1'b0;
        for (k = 0; k <= later; k++)
        begin
            @(posedge done_c);
            if (k == ref_off[row])
                reference_i <= 1'b1;
            if (k == gen_off[row])
                generated_i <= 1'b1;
            @(negedge done_c);
            if (pd_valid_o)
                report_failure("valid pulsed before the measurement closed");
        end
        edges = 0;
        got   = 1'b0;
        while (!got && edges < VALID_WAIT)
        begin
            @(posedge done_c);
            edges++;
            @(negedge done_c);
            got = pd_valid_o;
        end
        if (!got)
            report_failure("no valid pulse after both inputs rose");
        else
        begin
            if (edges != VALID_LATENCY)
                report_failure($sformatf("valid came %0d edges after the later input, not %0d",
                                         edges, VALID_LATENCY));
            check_outputs(row);
        end
        // Both inputs are still high here so nothing new may be measured
        repeat (HOLD_CYCLES)
        begin
            @(negedge done_c);
            if (pd_valid_o)
                report_failure("second valid while the inputs were held high");
            if (got)
                check_outputs(row);
        end
        @(posedge done_c);
        reference_i <= 1'b0;
        generated_i <= 1'b0;
        repeat (IDLE_CYCLES)
        begin
            @(negedge done_c);
            if (pd_valid_o)
                report_failure("valid pulsed while both inputs were low");
            if (got)
                check_outputs(row);  // Result holds until the next valid
        end
        close_test($sformatf("%0d ref=%0d gen=%0d", row, ref_off[row], gen_off[row]));
    endtask

    initial
    begin
        reset_i     <= 1'b1;
        reference_i <= 1'b0;
        generated_i <= 1'b0;
        seed        = 32'hfd3b9d58;
        pass_count  = 0;
        fail_count  = 0;

        set_row(0, 0, 0, 0, 1'b0);     // Same edge
        set_row(1, 0, 3, 3, 1'b0);
        set_row(2, 5, 0, -5, 1'b1);
        set_row(3, 0, 15, 15, 1'b0);
        set_row(4, 15, 0, -15, 1'b1);
        set_row(5, 0, 22, 15, 1'b0);   // Saturates
        set_row(6, 20, 2, -15, 1'b1);
        set_row(7, 4, 5, 1, 1'b0);
        set_row(8, 1, 0, -1, 1'b1);
        set_row(9, 7, 7, 0, 1'b0);
        for (int i = FIXED_ROWS; i < ROWS; i++)
        begin
            ref_off[i]  = ($random(seed) & 31) % 24;
            gen_off[i]  = ($random(seed) & 31) % 24;
            exp_err[i]  = rule_error(ref_off[i], gen_off[i]);
            exp_sign[i] = (gen_off[i] < ref_off[i]);
        end

        max_off = 0;
        for (int i = 0; i < ROWS; i++)
        begin
            if (ref_off[i] > max_off)
                max_off = ref_off[i];
            if (gen_off[i] > max_off)
                max_off = gen_off[i];
        end
        cycle_limit = ROWS * (max_off + 40);

        repeat (2) @(posedge done_c);
        reset_i <= 1'b0;

        @(negedge done_c);
        row_errors = 0;
        if (pd_valid_o !== 1'b0)
            report_value("pd_valid_o", int'(pd_valid_o), 0);
        if (gen_leads_o !== 1'b0)
            report_value("gen_leads_o", int'(gen_leads_o), 0);
        if (pd_error_o !== '0)
            report_value("pd_error_o", int'(pd_error_o), 0);
        close_test("reset");

        for (int i = 0; i < ROWS; i++)
            run_row(i);

        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule
